/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_decode_dga -f filelist.f -Mdir obj_dir
	./obj_dir/Vtb_decode_dga +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
+incdir+hw
hw/dga_pkg.sv
hw/panel_fifo.sv
hw/idb_source_decode.sv
hw/decode_dga.sv
tests/decode_dga_checker.sv
tests/tb_decode_dga.sv

/* hw/decode_dga.sv */
// Decode gate array panel path top, vector merge, address gating, decoder and FIFO
`default_nettype none

`include "dga_defs.svh"

module decode_dga import dga_pkg::*; (
  input  logic                  xclk,
  input  logic                  rst_n,
  input  logic                  clear,       // Master clear for the FIFO
  input  logic                  lcs_n,       // Load control store
  input  logic [`DGA_SRC_W-1:0] src_code,    // IDB source field
  input  logic                  ld_panc,     // Panel FIFO load strobe
  input  logic                  rmm_n,       // Panel reads FIFO, active low
  input  idb_byte_t             idb_in,      // IDB from the CPU
  input  logic [2:0]            pan_vector,  // Panel interrupt vector
  output logic [3:0]            idb_out,     // Low nibble back to the IDB
  output idb_byte_t             xa,          // Panel address bus
  output logic                  xepn,        // Vector on the bus, active low
  output idb_enables_t          en,
  output fifo_status_t          status
);

  logic [3:0] pan_nibble;
  idb_byte_t  fifo_din;
  idb_byte_t  fifo_head;
  logic       fifo_rd;

  // ***********************************************
  // Source decode
  // ***********************************************
  idb_source_decode u_idbs (
    .xclk     (xclk),
    .rst_n    (rst_n),
    .lcs_n    (lcs_n),
    .src_code (src_code),
    .en       (en)
  );

  // ***********************************************
  // Panel vector merge
  // ***********************************************
  // Bit 3 of the vector is always driven low
  assign pan_nibble = {1'b0, pan_vector};

  // High nibble passes, low nibble swapped while EPAN selected
  assign fifo_din = {idb_in[`DGA_IDB_W-1:4], en.epan_n ? idb_in[3:0] : pan_nibble};

  assign idb_out = en.epan_n ? idb_in[3:0] : pan_nibble;  // Echo unless vector
  assign xepn    = en.epan_n;                             // Tells the bus who drives

  // ***********************************************
  // Panel FIFO
  // ***********************************************
  assign fifo_rd = !rmm_n;  // Level read, one pop per cycle

  panel_fifo u_pfifo (
    .xclk   (xclk),
    .rst_n  (rst_n),
    .clear  (clear),
    .wr     (ld_panc),
    .rd     (fifo_rd),
    .din    (fifo_din),
    .dout   (fifo_head),
    .status (status)
  );

  // Address bus only driven while the panel reads
  assign xa = rmm_n ? '0 : fifo_head;

endmodule

`default_nettype wire

/* hw/dga_defs.svh */
// Macros for panel FIFO size, IDB bus widths and IDB source codes
`ifndef DGA_DEFS_SVH
`define DGA_DEFS_SVH

// ***********************************************
// Panel FIFO geometry
// ***********************************************
`define DGA_FIFO_DEPTH 13     // Entries in the panel FIFO
`define DGA_FIFO_AW    4      // Pointer bits for 13 slots

// ***********************************************
// Bus widths
// ***********************************************
`define DGA_IDB_W      8      // Internal data bus byte
`define DGA_SRC_W      5      // Microcode IDB source field

// ***********************************************
// IDB source codes
// ***********************************************
// Octal values as in the microcode listing
`define DGA_SRC_EPEA   5'd10  // Parity error address, 12 octal
`define DGA_SRC_EPES   5'd11  // Parity error status, 13 octal
`define DGA_SRC_EIOR   5'd14  // IO register (UART etc), 16 octal
`define DGA_SRC_EPANS0 5'd16  // Panel status low, 20 octal
`define DGA_SRC_EPANS1 5'd17  // Panel status high, 21 octal
`define DGA_SRC_ECSR   5'd20  // Cache status register, 24 octal
`define DGA_SRC_TRAALD 5'd22  // ALD and print status, 26 octal
`define DGA_SRC_EPAN   5'd23  // Panel interrupt vector, 27 octal
`define DGA_SRC_RINR   5'd29  // Installation number, 35 octal
`define DGA_SRC_RUART  5'd31  // UART read, 37 octal

// Codes 0-4, 6, 8, 9, 12, 21 and 30 all map to EDO
// and are listed directly in the decoder

// Codes not named here and not in the EDO group
// leave every enable inactive

`endif

/* hw/dga_pkg.sv */
// Package with IDB byte, source enable and panel FIFO status types
`default_nettype none

`include "dga_defs.svh"

package dga_pkg;

  // ***********************************************
  // Bus payload
  // ***********************************************
  typedef logic [`DGA_IDB_W-1:0] idb_byte_t;  // One IDB byte

  // ***********************************************
  // IDB source enables
  // ***********************************************
  // All active low, at most one low per cycle
  typedef struct packed {
    logic edo_n;     // Data out group
    logic eior_n;    // IO register
    logic epan_n;    // Panel interrupt vector
    logic epans_n;   // Panel status, either half
    logic epea_n;    // Parity error address
    logic epes_n;    // Parity error status
    logic ecsr_n;    // Cache status register
    logic rinr_n;    // Installation number
    logic ruart_n;   // UART read
    logic traald_n;  // ALD descriptor
  } idb_enables_t;

  // ***********************************************
  // Panel FIFO flags
  // ***********************************************
  typedef struct packed {
    logic emp_n;  // Low when nothing stored
    logic ful_n;  // Low with all 13 slots used
  } fifo_status_t;

  // Idle value of the enable bundle
  localparam idb_enables_t IDB_EN_IDLE = '1;

  // Flags of a freshly cleared FIFO
  localparam fifo_status_t FIFO_ST_CLEAR = '{emp_n: 1'b0, ful_n: 1'b1};

endpackage

`default_nettype wire

/* hw/idb_source_decode.sv */
// IDB source decoder, registered active-low enables from the microcode source field
`default_nettype none

`include "dga_defs.svh"

module idb_source_decode import dga_pkg::*; (
  input  logic                  xclk,
  input  logic                  rst_n,
  input  logic                  lcs_n,     // Low during control store load
  input  logic [`DGA_SRC_W-1:0] src_code,  // Microcode IDB source
  output idb_enables_t          en         // Registered, active low
);

  idb_enables_t en_next;

  // ***********************************************
  // Source decode
  // ***********************************************
  always_comb begin
    en_next = IDB_EN_IDLE;  // Nothing drives the bus by default

    // Control store load blocks every source
    if (lcs_n) begin
      case (src_code)
        // Sources outside the gate array share EDO
        5'd0, 5'd1, 5'd2, 5'd3, 5'd4,
        5'd6, 5'd8, 5'd9, 5'd12,
        5'd21, 5'd30: begin
          en_next.edo_n = 1'b0;
        end

        `DGA_SRC_EIOR:   en_next.eior_n   = 1'b0;  // UART and IO register
        `DGA_SRC_EPEA:   en_next.epea_n   = 1'b0;  // Parity error address
        `DGA_SRC_EPES:   en_next.epes_n   = 1'b0;  // Parity error status
        `DGA_SRC_ECSR:   en_next.ecsr_n   = 1'b0;  // Cache status
        `DGA_SRC_TRAALD: en_next.traald_n = 1'b0;  // TRA ALD
        `DGA_SRC_EPAN:   en_next.epan_n   = 1'b0;  // Panel vector
        `DGA_SRC_RINR:   en_next.rinr_n   = 1'b0;  // Installation number
        `DGA_SRC_RUART:  en_next.ruart_n  = 1'b0;  // UART data

        // Both panel status halves share one enable
        `DGA_SRC_EPANS0,
        `DGA_SRC_EPANS1: begin
          en_next.epans_n = 1'b0;
        end

        default: en_next = IDB_EN_IDLE;  // Unassigned code
      endcase
    end
  end

  // ***********************************************
  // Enable register
  // ***********************************************
  // Enables appear one cycle after the code
  always_ff @(posedge xclk) begin
    if (!rst_n) begin
      en <= IDB_EN_IDLE;
    end else begin
      en <= en_next;
    end
  end

endmodule

`default_nettype wire

/* hw/panel_fifo.sv */
// Panel FIFO, 13 deep byte buffer with first-word fall-through, flags and clear
`default_nettype none

`include "dga_defs.svh"

module panel_fifo import dga_pkg::*; (
  input  logic         xclk,
  input  logic         rst_n,
  input  logic         clear,   // Master clear, empties the buffer
  input  logic         wr,      // Load strobe
  input  logic         rd,      // Pop the head
  input  idb_byte_t    din,
  output idb_byte_t    dout,    // Head, valid while emp_n high
  output fifo_status_t status
);

  localparam int DEPTH  = `DGA_FIFO_DEPTH;
  localparam int AW     = `DGA_FIFO_AW;
  localparam int LAST_I = DEPTH - 1;

  localparam logic [AW-1:0] LAST     = LAST_I[AW-1:0];  // Wrap point
  localparam logic [AW:0]   FULL_CNT = DEPTH[AW:0];

  // ***********************************************
  // Storage and pointers
  // ***********************************************
  idb_byte_t     mem [DEPTH];  // No reset on payload
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;        // Occupancy 0..13

  logic empty;
  logic full;
  logic wr_ok;
  logic rd_ok;

  // Next slot, wraps after entry 12
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    ptr_inc = (p == LAST) ? '0 : p + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == FULL_CNT);

  // Read while empty is ignored
  assign rd_ok = rd && !empty;

  // Load while full is lost, unless the head leaves at the same edge
  assign wr_ok = wr && (!full || rd_ok);

  // ***********************************************
  // Data path
  // ***********************************************
  always_ff @(posedge xclk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;  // Tail slot
    end
  end

  assign dout = mem[rd_ptr];  // Fall-through head

  // ***********************************************
  // Control
  // ***********************************************
  always_ff @(posedge xclk) begin
    if (!rst_n || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_ok) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;  // Load only
        2'b01:   count <= count - 1'b1;  // Pop only
        default: count <= count;         // Both or neither
      endcase
    end
  end

  // Flags follow the count at the same edge
  assign status.emp_n = !empty;
  assign status.ful_n = !full;

endmodule

`default_nettype wire

/* tests/decode_dga_checker.sv */
// Bound assertions on IDB enables, panel FIFO flags and address gating
`default_nettype none

`include "dga_defs.svh"

module decode_dga_checker import dga_pkg::*; (
  input logic         xclk,
  input logic         rst_n,
  input logic         rmm_n,
  input idb_enables_t en,
  input fifo_status_t status,
  input idb_byte_t    xa
);

  timeunit 1ns;
  timeprecision 1ps;

  // Sticky flags, one per property
  logic en_bad   = 1'b0;
  logic flag_bad = 1'b0;
  logic xa_bad   = 1'b0;
  logic violation;

  assign violation = en_bad | flag_bad | xa_bad;  // Set once any property fails

  // **************************************************
  // Source enables
  // **************************************************
  a_one_enable: assert property (@(posedge xclk) disable iff (!rst_n) $onehot0(~en))
    else begin
      en_bad = 1'b1;
      $error("More than one IDB enable low, en=%h", en);
    end

  // **************************************************
  // FIFO flags and panel address
  // **************************************************
  a_flags: assert property (@(posedge xclk) disable iff (!rst_n) status.emp_n || status.ful_n)
    else begin
      flag_bad = 1'b1;
      $error("Full and empty both asserted, status=%h", status);
    end

  // Address bus idle unless the panel reads
  a_xa_gate: assert property (@(posedge xclk) disable iff (!rst_n) rmm_n |-> (xa == '0))
    else begin
      xa_bad = 1'b1;
      $error("xa driven while rmm_n high, xa=%h", xa);
    end

endmodule

bind decode_dga decode_dga_checker chk (
  .xclk   (xclk),
  .rst_n  (rst_n),
  .rmm_n  (rmm_n),
  .en     (en),
  .status (status),
  .xa     (xa)
);

`default_nettype wire

/* tests/dga_vectors.txt */
// Cols: clear lcs_n src_code ld_panc rmm_n idb_in pan_vector | exp en status xa idb_out
// Hex, one cycle per line; en is {edo_n..traald_n}, status is {emp_n, ful_n}
// Reset state and source decode
0 1 05 0 1 00 0 3FF 1 00 0
0 1 00 0 1 5A 0 3FF 1 00 A
0 1 0A 0 1 5A 0 1FF 1 00 A
0 1 0B 0 1 5A 0 3DF 1 00 A
0 1 0E 0 1 5A 0 3EF 1 00 A
0 1 10 0 1 5A 0 2FF 1 00 A
0 1 11 0 1 5A 0 3BF 1 00 A
0 1 14 0 1 5A 0 3BF 1 00 A
0 1 16 0 1 5A 0 3F7 1 00 A
0 1 1D 0 1 5A 0 3FE 1 00 A
0 1 1F 0 1 5A 0 3FB 1 00 A
0 1 15 0 1 5A 0 3FD 1 00 A
0 1 1E 0 1 5A 0 1FF 1 00 A
0 0 0A 0 1 5A 0 1FF 1 00 A
0 0 17 0 1 5A 0 3FF 1 00 A
0 1 13 0 1 5A 0 3FF 1 00 A
// Panel vector merge into the FIFO and onto the bus
0 1 17 0 1 C9 5 3FF 1 00 9
0 1 17 1 1 C9 6 37F 1 00 6
0 1 17 1 1 3F 7 37F 3 00 7
0 1 05 0 0 AB 7 37F 3 C6 7
0 1 05 0 0 AB 7 3FF 3 37 B
0 1 05 0 1 00 0 3FF 1 00 0
// Fill to 13, a lost 14th load, then drain in order
0 1 05 1 1 10 0 3FF 1 00 0
0 1 05 1 1 21 0 3FF 3 00 1
0 1 05 1 1 32 0 3FF 3 00 2
0 1 05 1 1 43 0 3FF 3 00 3
0 1 05 1 1 54 0 3FF 3 00 4
0 1 05 1 1 65 0 3FF 3 00 5
0 1 05 1 1 76 0 3FF 3 00 6
0 1 05 1 1 87 0 3FF 3 00 7
0 1 05 1 1 98 0 3FF 3 00 8
0 1 05 1 1 A9 0 3FF 3 00 9
0 1 05 1 1 BA 0 3FF 3 00 A
0 1 05 1 1 CB 0 3FF 3 00 B
0 1 05 1 1 DC 0 3FF 3 00 C
0 1 05 1 1 ED 0 3FF 2 00 D
0 1 05 0 0 00 0 3FF 2 10 0
0 1 05 0 0 00 0 3FF 3 21 0
0 1 05 0 0 00 0 3FF 3 32 0
0 1 05 0 0 00 0 3FF 3 43 0
0 1 05 0 0 00 0 3FF 3 54 0
0 1 05 0 0 00 0 3FF 3 65 0
0 1 05 0 0 00 0 3FF 3 76 0
0 1 05 0 0 00 0 3FF 3 87 0
0 1 05 0 0 00 0 3FF 3 98 0
0 1 05 0 0 00 0 3FF 3 A9 0
0 1 05 0 0 00 0 3FF 3 BA 0
0 1 05 0 0 00 0 3FF 3 CB 0
0 1 05 0 0 00 0 3FF 3 DC 0
0 1 05 0 1 00 0 3FF 1 00 0
// Load and read together, then master clear
0 1 05 1 1 11 0 3FF 1 00 1
0 1 05 1 1 22 0 3FF 3 00 2
0 1 05 1 0 33 0 3FF 3 11 3
0 1 05 1 0 44 0 3FF 3 22 4
1 1 05 0 1 00 0 3FF 3 00 0
0 1 05 0 1 00 0 3FF 1 00 0
0 1 05 1 1 55 0 3FF 1 00 5
0 1 05 0 0 00 0 3FF 3 55 0
0 1 05 0 1 00 0 3FF 1 00 0

/* tests/tb_decode_dga.sv */
// Testbench for decode_dga, vector file replay, LFSR FIFO traffic, queue model
`default_nettype none

`include "dga_defs.svh"

module tb_decode_dga import dga_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIELDS      = 11;    // Words per vector line
  localparam int MAX_WORDS   = 1024;
  localparam int RAND_CYCLES = 200;
  localparam int DEPTH       = `DGA_FIFO_DEPTH;

  // DUT signals
  logic                  xclk;
  logic                  rst_n;
  logic                  clear;
  logic                  lcs_n;
  logic [`DGA_SRC_W-1:0] src_code;
  logic                  ld_panc;
  logic                  rmm_n;
  idb_byte_t             idb_in;
  logic [2:0]            pan_vector;
  logic [3:0]            idb_out;
  idb_byte_t             xa;
  logic                  xepn;
  idb_enables_t          en;
  fifo_status_t          status;

  logic [15:0]  vec_mem [MAX_WORDS];
  logic [15:0]  line_w [FIELDS];    // Current vector line
  int           n_words;
  int           n_vec;
  int           base;
  int           cycle_count = 0;
  int           cycle_limit = 0;    // Zero until vectors are counted
  logic [31:0]  lfsr_state  = 32'haa87;
  logic [7:0]   wr_bits;
  logic [7:0]   rd_bits;
  logic [7:0]   rand_byte;
  logic         wr_req;
  logic         rd_req;
  logic         rd_ok;
  logic         wr_ok;
  fifo_status_t exp_st;
  idb_byte_t    model_q [$];        // Expected FIFO contents, head first

  decode_dga UUT (
    .xclk       (xclk),
    .rst_n      (rst_n),
    .clear      (clear),
    .lcs_n      (lcs_n),
    .src_code   (src_code),
    .ld_panc    (ld_panc),
    .rmm_n      (rmm_n),
    .idb_in     (idb_in),
    .pan_vector (pan_vector),
    .idb_out    (idb_out),
    .xa         (xa),
    .xepn       (xepn),
    .en         (en),
    .status     (status)
  );

  // **************************************************
  // Clock and cycle limit
  // **************************************************
  initial begin
    xclk = 1'b0;
    forever #20 xclk = ~xclk;  // 40 ns period
  end

  always @(posedge xclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("TEST FAIL");
      $fatal(1, "Timeout, run went past %0d cycles", cycle_limit);
    end
  end

  // Bound assertions, stop at the first one that fires
  always @(negedge xclk) begin
    if (UUT.chk.violation) begin
      $display("TEST FAIL");
      $fatal(1, "Bound checker reported an assertion failure");
    end
  end

  // **************************************************
  // Helpers
  // **************************************************
  function automatic logic [15:0] vec_word(input int idx);
    vec_word = vec_mem[10'(idx)];
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      val = {val[6:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      $display("TEST FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // **************************************************
  // Main sequence
  // **************************************************
  initial begin
    rst_n      = 1'b0;
    clear      = 1'b0;
    lcs_n      = 1'b1;
    src_code   = 5'd5;   // Unassigned code
    ld_panc    = 1'b0;
    rmm_n      = 1'b1;
    idb_in     = '0;
    pan_vector = '0;

    for (int i = 0; i < MAX_WORDS; i++) vec_mem[i] = 16'hffff;  // End marker
    $readmemh("tests/dga_vectors.txt", vec_mem);
    n_words = 0;
    while (n_words < MAX_WORDS && vec_word(n_words) != 16'hffff) n_words++;
    if (n_words == 0 || n_words % FIELDS != 0) begin
      $display("TEST FAIL");
      $fatal(1, "Vector file is missing or has an incomplete line");
    end
    n_vec       = n_words / FIELDS;
    cycle_limit = n_vec + 400;

    repeat (10) @(posedge xclk);
    #2 rst_n = 1'b1;

    // Vector replay, outputs checked mid cycle
    for (int v = 0; v < n_vec; v++) begin
      base = v * FIELDS;
      for (int k = 0; k < FIELDS; k++) begin
        line_w[k] = vec_word(base + k);
      end
      @(posedge xclk);
      #2;
      clear      = line_w[0][0];
      lcs_n      = line_w[1][0];
      src_code   = line_w[2][4:0];
      ld_panc    = line_w[3][0];
      rmm_n      = line_w[4][0];
      idb_in     = line_w[5][7:0];
      pan_vector = line_w[6][2:0];
      #10;
      check_value("en", 32'(en), 32'(line_w[7]));
      check_value("xepn", 32'(xepn), 32'(line_w[7][7]));  // epan_n copy
      check_value("status", 32'(status), 32'(line_w[8]));
      check_value("xa", 32'(xa), 32'(line_w[9]));
      check_value("idb_out", 32'(idb_out), 32'(line_w[10]));
    end

    // Random traffic, fill-heavy first half, drain-heavy second
    for (int c = 0; c < RAND_CYCLES; c++) begin
      draw_bits(2, wr_bits);
      draw_bits(2, rd_bits);
      draw_bits(8, rand_byte);
      if (c < RAND_CYCLES / 2) begin
        wr_req = |wr_bits[1:0];
        rd_req = &rd_bits[1:0];
      end else begin
        wr_req = &wr_bits[1:0];
        rd_req = |rd_bits[1:0];
      end
      @(posedge xclk);
      #2;
      clear    = 1'b0;
      lcs_n    = 1'b1;
      src_code = 5'd5;
      ld_panc  = wr_req;
      rmm_n    = !rd_req;
      idb_in   = rand_byte;
      #10;
      exp_st.emp_n = (model_q.size() != 0);
      exp_st.ful_n = (model_q.size() != DEPTH);
      check_value("status", 32'(status), 32'(exp_st));
      check_value("en", 32'(en), 32'h3ff);  // All ten enables high
      check_value("idb_out", 32'(idb_out), 32'(rand_byte[3:0]));
      if (!rd_req) begin
        check_value("xa", 32'(xa), 32'h0);
      end else if (model_q.size() != 0) begin
        check_value("xa", 32'(xa), 32'(model_q[0]));  // Head in load order
      end
      // Model update for the coming edge
      rd_ok = rd_req && (model_q.size() != 0);
      wr_ok = wr_req && ((model_q.size() < DEPTH) || rd_ok);
      if (rd_ok) void'(model_q.pop_front());
      if (wr_ok) model_q.push_back(rand_byte);
    end

    @(posedge xclk);
    #2;
    ld_panc = 1'b0;
    rmm_n   = 1'b1;

    if (!UUT.chk.violation) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "Bound checker reported an assertion failure");
    end
  end

endmodule

`default_nettype wire
